/* bpu_golden.txt */
# columns: name kind pc inst taken target ctl exp_cti exp_taken exp_pc
# kind q=query u=update p=push b=push and query, ctl bit1 stall bit0 flush
r_nop         q 00001000 00000013 0 00000000 0 0 0 00001004
r_branch      q 00001100 00000863 0 00000000 0 1 0 00001104
r_jalr        q 00001200 00030067 0 00000000 0 1 0 00001204
b_upd1        u 00001100 00000863 1 00002000 0 0 0 00000000
b_alias_off   q 00001500 00000863 0 00000000 0 1 1 00001510
b_btb_hit     q 00001100 00000863 0 00000000 0 1 1 00002000
b_upd2        u 00001100 00000863 1 00002000 0 0 0 00000000
b_upd3        u 00001100 00000863 1 00002000 0 0 0 00000000
b_saturated   q 00001100 00000863 0 00000000 0 1 1 00002000
b_nt1         u 00001100 00000863 0 00002000 0 0 0 00000000
b_after_nt1   q 00001100 00000863 0 00000000 0 1 1 00002000
b_nt2         u 00001100 00000863 0 00002000 0 0 0 00000000
b_after_nt2   q 00001100 00000863 0 00000000 0 1 0 00001104
j_miss        q 00003000 100000ef 0 00000000 0 1 1 00003100
j_upd         u 00003000 100000ef 1 00004440 0 0 0 00000000
j_hit         q 00003000 100000ef 0 00000000 0 1 1 00004440
j_alias       q 00003400 100000ef 0 00000000 0 1 1 00003500
s_empty       q 00005000 00008067 0 00000000 0 1 0 00005004
s_push_a      p 00000000 00000013 0 0000a000 0 0 0 00000000
s_push_b      p 00000000 00000013 0 0000b000 0 0 0 00000000
s_top_b       q 00005000 00008067 0 00000000 0 1 1 0000b000
s_pop_b       u 00005000 00008067 1 0000b000 0 0 0 00000000
s_top_a       q 00005000 00008067 0 00000000 0 1 1 0000a000
s_pop_a       u 00005000 00008067 1 0000a000 0 0 0 00000000
s_empty_again q 00005000 00008067 0 00000000 0 1 0 00005004
x_bypass      b 00005000 00008067 0 0000c000 0 1 1 0000c000
x_after_byp   q 00005000 00008067 0 00000000 0 1 1 0000c000
x_push_stall  p 00000000 00000013 0 0000d000 2 0 0 00000000
x_q_stall     q 00005000 00008067 0 00000000 0 1 1 0000c000
x_push_flush  p 00000000 00000013 0 0000e000 1 0 0 00000000
x_q_flush     q 00005000 00008067 0 00000000 0 1 1 0000c000
x_pop_stall   u 00005000 00008067 1 0000c000 2 0 0 00000000
x_q_pop_stall q 00005000 00008067 0 00000000 0 1 1 0000c000
x_pop_flush   u 00005000 00008067 1 0000c000 1 0 0 00000000
x_q_pop_flush q 00005000 00008067 0 00000000 0 1 1 0000c000

/* sources.f */
bpu_cfg_pkg.sv
rv_inst_pkg.sv
inst_classify.sv
bimodal_table.sv
branch_target_buffer.sv
return_addr_stack.sv
bpu_top.sv
bpu_checker.sv
tb_bpu.sv

/* run_sim.sh */
#!/bin/sh
# build with Verilator, run, and pass only if the testbench reports a pass
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sources.f --top-module tb_bpu -o tb_bpu \
    && ./obj_dir/tb_bpu | tee /dev/stderr | grep -qF "Simulation finished: PASS" \
    && { echo "run_sim: passed"; exit 0; } \
    || { echo "run_sim: failed"; exit 1; }

/* tb_bpu.sv */
`timescale 1ns/1ps

module tb_bpu;
    import bpu_cfg_pkg::*;

    localparam int    CLK_PERIOD  = 100;
    localparam int    RST_CYCLES  = 10;
    localparam int    LINE_W      = 8 * 128;
    localparam string GOLDEN_FILE = "bpu_golden.txt";

    logic            clk = 1'b0;
    logic            rst;
    logic [XLEN-1:0] if_pc, if_inst;
    logic            ex_valid, ex_taken;
    logic [XLEN-1:0] ex_pc, ex_target, ex_inst;
    logic            push_valid;
    logic [XLEN-1:0] push_data;
    logic            stall, flush;
    logic            is_cti, pdt_taken;
    logic [XLEN-1:0] pdt_pc;

    // expected values handed to the checker
    logic            chk_valid;
    logic [127:0]    chk_name;
    logic            chk_cti, chk_taken;
    logic [XLEN-1:0] chk_pc;

    // fields of the current golden line
    logic [127:0]    step_name;
    logic [7:0]      step_kind;
    logic [XLEN-1:0] step_pc, step_inst, step_target, step_exp_pc;
    logic            step_taken, step_cti, step_exp_taken;
    logic [1:0]      step_ctl;

    int n_steps = 0;
    int pass_cnt, fail_cnt;

    always #(CLK_PERIOD / 2) clk = ~clk;

    bpu_top u_dut (
        .clk                 (clk),
        .rst                 (rst),
        .if_pc_i             (if_pc),
        .if_inst_i           (if_inst),
        .ex_branch_valid_i   (ex_valid),
        .ex_branch_taken_i   (ex_taken),
        .ex_pc_i             (ex_pc),
        .ex_target_i         (ex_target),
        .ex_inst_i           (ex_inst),
        .id_ras_push_valid_i (push_valid),
        .id_ras_push_data_i  (push_data),
        .stall_i             (stall),
        .flush_i             (flush),
        .is_cti_o            (is_cti),
        .pdt_taken_o         (pdt_taken),
        .pdt_pc_o            (pdt_pc)
    );

    bpu_checker u_chk (
        .clk         (clk),
        .check_i     (chk_valid),
        .name_i      (chk_name),
        .exp_cti_i   (chk_cti),
        .exp_taken_i (chk_taken),
        .exp_pc_i    (chk_pc),
        .is_cti_i    (is_cti),
        .pdt_taken_i (pdt_taken),
        .pdt_pc_i    (pdt_pc),
        .pass_cnt_o  (pass_cnt),
        .fail_cnt_o  (fail_cnt)
    );

    task automatic parse_line(input logic [LINE_W-1:0] line, output bit ok);
        int n;
        n = $sscanf(line, "%s %s %h %h %h %h %h %h %h %h", step_name, step_kind, step_pc,
                    step_inst, step_taken, step_target, step_ctl, step_cti, step_exp_taken,
                    step_exp_pc);
        // comment and blank lines fail the field count
        ok = (n == 10) && (step_kind == "q" || step_kind == "u" || step_kind == "p"
                           || step_kind == "b");
    endtask

    task automatic count_steps(output int cnt);
        int fd;
        bit ok;
        logic [LINE_W-1:0] line;
        cnt = 0;
        fd = $fopen(GOLDEN_FILE, "r");
        if (fd != 0) begin
            while ($fgets(line, fd) != 0) begin
                parse_line(line, ok);
                if (ok) begin
                    cnt++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic drive_step();
        if_pc      <= step_pc;
        if_inst    <= step_inst;
        ex_pc      <= step_pc;      // same columns feed the execute side
        ex_inst    <= step_inst;
        ex_target  <= step_target;
        ex_taken   <= step_taken;
        ex_valid   <= (step_kind == "u");
        push_data  <= step_target;  // target column doubles as push data
        push_valid <= (step_kind == "p") || (step_kind == "b");
        stall      <= step_ctl[1];
        flush      <= step_ctl[0];
        chk_valid  <= (step_kind == "q") || (step_kind == "b");
        chk_name   <= step_name;
        chk_cti    <= step_cti;
        chk_taken  <= step_exp_taken;
        chk_pc     <= step_exp_pc;
    endtask

    task automatic drive_idle();
        ex_valid   <= 1'b0;
        push_valid <= 1'b0;
        stall      <= 1'b0;
        flush      <= 1'b0;
        chk_valid  <= 1'b0;
    endtask

    initial begin
        int fd;
        bit ok;
        bit file_err;
        logic [LINE_W-1:0] line;
        rst       <= 1'b1;
        if_pc     <= '0;
        if_inst   <= '0;
        ex_pc     <= '0;
        ex_inst   <= '0;
        ex_target <= '0;
        ex_taken  <= 1'b0;
        push_data <= '0;
        chk_name  <= '0;
        chk_cti   <= 1'b0;
        chk_taken <= 1'b0;
        chk_pc    <= '0;
        drive_idle();
        file_err = 1'b0;
        count_steps(n_steps);
        fd = $fopen(GOLDEN_FILE, "r");
        if (fd == 0) begin
            $display("could not open %s for reading", GOLDEN_FILE);
            file_err = 1'b1;
        end
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;
        if (!file_err) begin
            while ($fgets(line, fd) != 0) begin
                parse_line(line, ok);
                if (ok) begin
                    @(posedge clk);
                    drive_step();
                end
            end
            $fclose(fd);
        end
        @(posedge clk);
        drive_idle();
        @(negedge clk);   // last check has been counted
        $display("tests done: %0d passed, %0d failed", pass_cnt, fail_cnt);
        if (!file_err && fail_cnt == 0 && pass_cnt > 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // four periods per golden step plus reset
    initial begin
        wait (n_steps > 0);
        #(CLK_PERIOD * (n_steps * 4 + RST_CYCLES));
        $display("run timed out before all %0d golden steps finished", n_steps);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

/* bpu_checker.sv */
`timescale 1ns/1ps

module bpu_checker (
    input  logic                         clk,
    input  logic                         check_i,
    input  logic [127:0]                 name_i,
    input  logic                         exp_cti_i,
    input  logic                         exp_taken_i,
    input  logic [bpu_cfg_pkg::XLEN-1:0] exp_pc_i,
    // prediction from the DUT
    input  logic                         is_cti_i,
    input  logic                         pdt_taken_i,
    input  logic [bpu_cfg_pkg::XLEN-1:0] pdt_pc_i,
    output int                           pass_cnt_o,
    output int                           fail_cnt_o
);
    int pass_cnt = 0;
    int fail_cnt = 0;

    assign pass_cnt_o = pass_cnt;
    assign fail_cnt_o = fail_cnt;

    // prediction is combinational, settled by the falling edge
    always @(negedge clk) begin
        if (check_i) begin
            if (is_cti_i === exp_cti_i && pdt_taken_i === exp_taken_i
                && pdt_pc_i === exp_pc_i) begin
                $display("PASS %0s", name_i);
                pass_cnt <= pass_cnt + 1;
            end else begin
                $write("FAIL %0s expected cti=%0b taken=%0b pc=%h,",
                       name_i, exp_cti_i, exp_taken_i, exp_pc_i);
                $display(" actual cti=%0b taken=%0b pc=%h",
                         is_cti_i, pdt_taken_i, pdt_pc_i);
                fail_cnt <= fail_cnt + 1;
            end
        end
    end

endmodule

/* bpu_top.sv */
`timescale 1ns/1ps

module bpu_top #(
    parameter int BHT_ENTRIES = bpu_cfg_pkg::BHT_ENTRIES,
    parameter int BTB_ENTRIES = bpu_cfg_pkg::BTB_ENTRIES,
    parameter int RAS_DEPTH   = bpu_cfg_pkg::RAS_DEPTH
) (
    input  logic                         clk,
    input  logic                         rst,
    // fetch
    input  logic [bpu_cfg_pkg::XLEN-1:0] if_pc_i,
    input  logic [bpu_cfg_pkg::XLEN-1:0] if_inst_i,
    // execute resolution
    input  logic                         ex_branch_valid_i,
    input  logic                         ex_branch_taken_i,
    input  logic [bpu_cfg_pkg::XLEN-1:0] ex_pc_i,
    input  logic [bpu_cfg_pkg::XLEN-1:0] ex_target_i,
    input  logic [bpu_cfg_pkg::XLEN-1:0] ex_inst_i,
    // decode call push
    input  logic                         id_ras_push_valid_i,
    input  logic [bpu_cfg_pkg::XLEN-1:0] id_ras_push_data_i,
    input  logic                         stall_i,
    input  logic                         flush_i,
    // prediction
    output logic                         is_cti_o,
    output logic                         pdt_taken_o,
    output logic [bpu_cfg_pkg::XLEN-1:0] pdt_pc_o
);
    import bpu_cfg_pkg::*;
    import rv_inst_pkg::*;

    inst_class_e     if_cls;
    logic            if_is_ret;
    logic [XLEN-1:0] if_br_off;
    logic [XLEN-1:0] if_jal_off;
    logic            ex_is_ret;

    logic            bht_taken;
    logic            btb_hit;
    logic [XLEN-1:0] btb_target;
    logic [XLEN-1:0] ras_top;
    logic            ras_empty;
    logic            ras_push;
    logic            ras_pop;
    logic            btb_wr;
    logic [XLEN-1:0] pc_seq;

    assign pc_seq = if_pc_i + XLEN'(INST_BYTES);

    // stack ops are dropped while the pipe is held or flushed
    assign ras_push = id_ras_push_valid_i && !stall_i && !flush_i;
    assign ras_pop  = ex_branch_valid_i && ex_branch_taken_i && ex_is_ret
                      && !stall_i && !flush_i;
    assign btb_wr   = ex_branch_valid_i && ex_branch_taken_i;

    inst_classify u_if_cls (
        .inst_i    (if_inst_i),
        .cls_o     (if_cls),
        .is_ret_o  (if_is_ret),
        .br_off_o  (if_br_off),
        .jal_off_o (if_jal_off)
    );

    // only the return flag is needed on the execute side
    inst_classify u_ex_cls (
        .inst_i    (ex_inst_i),
        .cls_o     (),
        .is_ret_o  (ex_is_ret),
        .br_off_o  (),
        .jal_off_o ()
    );

    bimodal_table #(.ENTRIES(BHT_ENTRIES)) u_bht (
        .clk         (clk),
        .rst         (rst),
        .rd_pc_i     (if_pc_i),
        .rd_taken_o  (bht_taken),
        .upd_valid_i (ex_branch_valid_i),
        .upd_pc_i    (ex_pc_i),
        .upd_taken_i (ex_branch_taken_i)
    );

    branch_target_buffer #(.ENTRIES(BTB_ENTRIES)) u_btb (
        .clk         (clk),
        .rst         (rst),
        .rd_pc_i     (if_pc_i),
        .hit_o       (btb_hit),
        .target_o    (btb_target),
        .wr_valid_i  (btb_wr),
        .wr_pc_i     (ex_pc_i),
        .wr_target_i (ex_target_i)
    );

    return_addr_stack #(.DEPTH(RAS_DEPTH)) u_ras (
        .clk         (clk),
        .rst         (rst),
        .push_i      (ras_push),
        .push_data_i (id_ras_push_data_i),
        .pop_i       (ras_pop),
        .top_o       (ras_top),
        .empty_o     (ras_empty)
    );

    always_comb begin
        is_cti_o    = 1'b0;
        pdt_taken_o = 1'b0;
        pdt_pc_o    = pc_seq;   // fall-through default
        case (if_cls)
            CLS_JAL: begin
                is_cti_o    = 1'b1;
                pdt_taken_o = 1'b1;
                pdt_pc_o    = btb_hit ? btb_target : if_pc_i + if_jal_off;
            end
            CLS_BRANCH, CLS_JALR: begin
                is_cti_o = 1'b1;
                if (if_is_ret) begin
                    if (id_ras_push_valid_i) begin   // call decoded this cycle
                        pdt_taken_o = 1'b1;
                        pdt_pc_o    = id_ras_push_data_i;
                    end else if (!ras_empty) begin
                        pdt_taken_o = 1'b1;
                        pdt_pc_o    = ras_top;
                    end
                end else begin
                    pdt_taken_o = bht_taken;
                    if (bht_taken) begin
                        if (btb_hit) begin
                            pdt_pc_o = btb_target;
                        end else if (if_cls == CLS_BRANCH) begin
                            pdt_pc_o = if_pc_i + if_br_off;
                        end
                        // jalr miss stays on pc + 4
                    end
                end
            end
            default: ;
        endcase
    end

endmodule

/* return_addr_stack.sv */
`timescale 1ns/1ps

module return_addr_stack #(
    parameter int DEPTH = bpu_cfg_pkg::RAS_DEPTH
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         push_i,
    input  logic [bpu_cfg_pkg::XLEN-1:0] push_data_i,
    input  logic                         pop_i,
    output logic [bpu_cfg_pkg::XLEN-1:0] top_o,
    output logic                         empty_o
);
    import bpu_cfg_pkg::*;

    localparam int IDX_W = $clog2(DEPTH);
    localparam int PTR_W = IDX_W + 1;   // pointer counts 0..DEPTH

    logic [XLEN-1:0]  stack_q [DEPTH];
    logic [PTR_W-1:0] sp_q;             // next free slot

    logic [PTR_W-1:0] sp_dec;
    logic [PTR_W-1:0] sp_pop;
    logic             do_pop;
    logic             do_push;

    assign empty_o = (sp_q == '0);
    assign sp_dec  = sp_q - 1'b1;

    // entry below the pointer
    // index wraps when empty, caller checks empty_o
    assign top_o = stack_q[sp_dec[IDX_W-1:0]];

    // pop goes first, push then lands on the post-pop slot
    assign do_pop  = pop_i && !empty_o;
    assign sp_pop  = do_pop ? sp_dec : sp_q;
    assign do_push = push_i && (sp_pop != PTR_W'(DEPTH));   // full check after the pop

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sp_q <= '0;
        end else begin
            if (do_push) begin
                sp_q <= sp_pop + 1'b1;
            end else begin
                sp_q <= sp_pop;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            stack_q[sp_pop[IDX_W-1:0]] <= push_data_i;
        end
    end

endmodule

/* branch_target_buffer.sv */
`timescale 1ns/1ps

module branch_target_buffer #(
    parameter int ENTRIES = bpu_cfg_pkg::BTB_ENTRIES
) (
    input  logic                         clk,
    input  logic                         rst,
    // fetch lookup
    input  logic [bpu_cfg_pkg::XLEN-1:0] rd_pc_i,
    output logic                         hit_o,
    output logic [bpu_cfg_pkg::XLEN-1:0] target_o,
    // execute write, taken only
    input  logic                         wr_valid_i,
    input  logic [bpu_cfg_pkg::XLEN-1:0] wr_pc_i,
    input  logic [bpu_cfg_pkg::XLEN-1:0] wr_target_i
);
    import bpu_cfg_pkg::*;

    localparam int IDX_W = $clog2(ENTRIES);
    localparam int TAG_LSB = BTB_INDEX_LSB + IDX_W;
    localparam int TAG_W = XLEN - TAG_LSB;   // everything above the index

    logic             valid_q  [ENTRIES];
    logic [TAG_W-1:0] tag_q    [ENTRIES];
    logic [XLEN-1:0]  target_q [ENTRIES];

    logic [IDX_W-1:0] rd_idx;
    logic [TAG_W-1:0] rd_tag;
    logic [IDX_W-1:0] wr_idx;
    logic [TAG_W-1:0] wr_tag;

    assign rd_idx = rd_pc_i[BTB_INDEX_LSB +: IDX_W];
    assign rd_tag = rd_pc_i[XLEN-1:TAG_LSB];
    assign wr_idx = wr_pc_i[BTB_INDEX_LSB +: IDX_W];
    assign wr_tag = wr_pc_i[XLEN-1:TAG_LSB];

    assign hit_o    = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
    assign target_o = target_q[rd_idx];

    // valid bits
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < ENTRIES; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else if (wr_valid_i) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // tag and target storage
    always_ff @(posedge clk) begin
        if (wr_valid_i) begin
            tag_q[wr_idx]    <= wr_tag;   // replaces any alias
            target_q[wr_idx] <= wr_target_i;
        end
    end

endmodule

/* bimodal_table.sv */
`timescale 1ns/1ps

module bimodal_table #(
    parameter int ENTRIES = bpu_cfg_pkg::BHT_ENTRIES
) (
    input  logic                         clk,
    input  logic                         rst,
    // fetch lookup
    input  logic [bpu_cfg_pkg::XLEN-1:0] rd_pc_i,
    output logic                         rd_taken_o,
    // execute resolution
    input  logic                         upd_valid_i,
    input  logic [bpu_cfg_pkg::XLEN-1:0] upd_pc_i,
    input  logic                         upd_taken_i
);
    import bpu_cfg_pkg::*;

    localparam int IDX_W = $clog2(ENTRIES);

    logic [CNT_W-1:0] cnt_q [ENTRIES];
    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] upd_idx;
    logic [CNT_W-1:0] upd_cnt;

    assign rd_idx  = rd_pc_i[BHT_INDEX_LSB +: IDX_W];
    assign upd_idx = upd_pc_i[BHT_INDEX_LSB +: IDX_W];
    assign upd_cnt = cnt_q[upd_idx];

    // msb of the counter is the direction
    assign rd_taken_o = cnt_q[rd_idx][CNT_W-1];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < ENTRIES; i++) begin
                cnt_q[i] <= CNT_RESET;
            end
        end else if (upd_valid_i) begin
            if (upd_taken_i) begin
                if (upd_cnt != {CNT_W{1'b1}}) begin   // saturate at 11
                    cnt_q[upd_idx] <= upd_cnt + 1'b1;
                end
            end else begin
                if (upd_cnt != {CNT_W{1'b0}}) begin   // saturate at 00
                    cnt_q[upd_idx] <= upd_cnt - 1'b1;
                end
            end
        end
    end

endmodule

/* inst_classify.sv */
`timescale 1ns/1ps

module inst_classify (
    input  logic [bpu_cfg_pkg::XLEN-1:0] inst_i,
    output rv_inst_pkg::inst_class_e     cls_o,
    output logic                         is_ret_o,
    output logic [bpu_cfg_pkg::XLEN-1:0] br_off_o,
    output logic [bpu_cfg_pkg::XLEN-1:0] jal_off_o
);
    import bpu_cfg_pkg::*;
    import rv_inst_pkg::*;

    opcode_e    opcode;
    logic [4:0] rs1;

    assign opcode = opcode_e'(inst_i[6:0]);
    assign rs1    = inst_i[19:15];

    always_comb begin
        case (opcode)
            OP_BRANCH: cls_o = CLS_BRANCH;
            OP_JAL:    cls_o = CLS_JAL;
            OP_JALR:   cls_o = CLS_JALR;
            default:   cls_o = CLS_NONE;
        endcase
    end

    // return = jalr through ra or t0
    // rd is left out on purpose, execute side uses the same test
    assign is_ret_o = (opcode == OP_JALR) && ((rs1 == REG_RA) || (rs1 == REG_T0));

    // B-type immediate, 13 bits, lsb always zero
    assign br_off_o = {
        {(XLEN-12){inst_i[31]}},
        inst_i[7],
        inst_i[30:25],
        inst_i[11:8],
        1'b0
    };

    // J-type immediate, 21 bits
    assign jal_off_o = {
        {(XLEN-20){inst_i[31]}},
        inst_i[19:12],
        inst_i[20],
        inst_i[30:21],
        1'b0
    };

endmodule

/* rv_inst_pkg.sv */
package rv_inst_pkg;

    // base opcodes, inst[6:0]
    typedef enum logic [6:0] {
        OP_LOAD   = 7'b0000011,
        OP_FENCE  = 7'b0001111,
        OP_IMM    = 7'b0010011,
        OP_AUIPC  = 7'b0010111,
        OP_STORE  = 7'b0100011,
        OP_REG    = 7'b0110011,
        OP_LUI    = 7'b0110111,
        OP_BRANCH = 7'b1100011,
        OP_JALR   = 7'b1100111,
        OP_JAL    = 7'b1101111,
        OP_SYSTEM = 7'b1110011
    } opcode_e;

    // what the predictor cares about
    typedef enum logic [1:0] {
        CLS_NONE   = 2'b00,
        CLS_BRANCH = 2'b01,
        CLS_JAL    = 2'b10,
        CLS_JALR   = 2'b11
    } inst_class_e;

    // link registers per the calling convention
    localparam logic [4:0] REG_RA = 5'd1;
    localparam logic [4:0] REG_T0 = 5'd5;

endpackage

/* bpu_cfg_pkg.sv */
package bpu_cfg_pkg;

    // datapath width, PC and instruction alike
    localparam int XLEN = 32;

    // default table sizes, the top level may override them
    localparam int BHT_ENTRIES = 512;   // bimodal counters
    localparam int BTB_ENTRIES = 256;   // direct-mapped target entries
    localparam int RAS_DEPTH   = 64;    // return stack entries

    // 2-bit saturating direction counter
    localparam int CNT_W = 2;
    // weakly not taken
    localparam logic [CNT_W-1:0] CNT_RESET = 2'b01;

    // pc bits skipped below the table index
    localparam int BTB_INDEX_LSB = 2;   // word aligned targets
    localparam int BHT_INDEX_LSB = 1;   // halfword granularity, leaves room for rvc

    // sequential fetch step
    localparam int INST_BYTES = 4;

endpackage
